//--- build.f
+incdir+logic
+incdir+tests
logic/bus_pkg.sv
logic/pipe_pkg.sv
logic/pc_sequencer.sv
logic/apb_arbiter.sv
logic/code_memory.sv
logic/fetch_buffer.sv
logic/fetch_top.sv
tests/tb_fetch.sv

//--- tests/tb_fetch_tasks.svh
`ifndef TB_FETCH_TASKS_SVH
`define TB_FETCH_TASKS_SVH

task automatic begin_test(input string name);
        cur_test  = name;
        test_errs = 0;
endtask

task automatic end_test();
        tests_run++;
        if (test_errs == 0)
                $display("%s: passed", cur_test);
        else
        begin
                tests_failed++;
                $display("%s: failed with %0d errors", cur_test, test_errs);
        end
endtask

task automatic cmp_word(input string what, input pipe_pkg::word_t exp,
                        input pipe_pkg::word_t act);
        checks++;
        if (act !== exp)
        begin
                errors++;
                test_errs++;
                $display("ERR %s %s: expected %h, actual %h", cur_test, what, exp, act);
        end
endtask

task automatic cmp_addr(input string what, input pipe_pkg::addr_t exp,
                        input pipe_pkg::addr_t act);
        checks++;
        if (act !== exp)
        begin
                errors++;
                test_errs++;
                $display("ERR %s %s: expected %h, actual %h", cur_test, what, exp, act);
        end
endtask

task automatic cmp_bit(input string what, input logic exp, input logic act);
        checks++;
        if (act !== exp)
        begin
                errors++;
                test_errs++;
                $display("ERR %s %s: expected %b, actual %b", cur_test, what, exp, act);
        end
endtask

// One APB transfer on the maintenance port, held until pready.
task automatic ext_xfer(input logic wr, input pipe_pkg::addr_t addr,
                        input pipe_pkg::word_t wdata, output pipe_pkg::word_t rdata,
                        output logic err);
        bus_pkg::apb_req_t req;
        req        = '0;
        req.paddr  = addr;
        req.pwdata = wdata;
        req.pwrite = wr;
        req.psel   = 1'b1;
        @(posedge i_clk);
        i_ext_req <= req;               // SETUP.
        req.penable = 1'b1;
        @(posedge i_clk);
        i_ext_req <= req;               // ACCESS.
        @(negedge i_clk);
        while (!o_ext_rsp.pready)
                @(negedge i_clk);       // Arbiter may be busy with fetch.
        rdata = o_ext_rsp.prdata;
        err   = o_ext_rsp.pslverr;
        @(posedge i_clk);
        i_ext_req <= '0;
endtask

// What a fetch from pc must deliver.
function automatic pipe_pkg::fetch_bundle_t expected_bundle(input pipe_pkg::addr_t pc);
        pipe_pkg::fetch_bundle_t b;
        b.valid     = 1'b1;
        b.pc_plus_8 = pc + 32'd8;
        b.abort     = (pc >= MEM_BYTES);        // Past the array, slave error.
        b.instr     = '0;
        if (!b.abort)
                b.instr = model[pc >> 2];
        return b;
endfunction

// Follows o_fetch until n words are consumed, with optional random stalls.
task automatic watch_fetch(input int n, input logic stall_en);
        pipe_pkg::fetch_bundle_t prev;
        pipe_pkg::fetch_bundle_t exp;
        logic                    held;
        int                      got;
        int                      stall_left;
        prev       = '0;
        held       = 1'b0;
        got        = 0;
        stall_left = 0;
        while (got < n)
        begin
                @(posedge i_clk);
                if (stall_en)
                begin
                        if (stall_left > 0)
                                stall_left--;
                        else if (rand_bits(2) == 0)
                                stall_left = 1 + rand_bits(3);  // 1 to 8 cycles.
                        i_stall <= (stall_left > 0);
                end
                @(negedge i_clk);
                if (held)
                begin
                        cmp_word("instr held in stall", prev.instr, o_fetch.instr);
                        cmp_addr("pc_plus_8 held in stall", prev.pc_plus_8, o_fetch.pc_plus_8);
                        cmp_bit("valid held in stall", prev.valid, o_fetch.valid);
                end
                if (o_fetch.valid && !i_stall)  // Consumed at the coming edge.
                begin
                        exp = expected_bundle(exp_pc);
                        cmp_word($sformatf("instr at %h", exp_pc), exp.instr, o_fetch.instr);
                        cmp_addr($sformatf("pc_plus_8 at %h", exp_pc), exp.pc_plus_8,
                                 o_fetch.pc_plus_8);
                        cmp_bit($sformatf("abort at %h", exp_pc), exp.abort, o_fetch.abort);
                        exp_pc += 32'd4;
                        got++;
                end
                held = i_stall;
                prev = o_fetch;
        end
endtask

// Clear pulse; output must be empty the cycle after.
task automatic redirect_to(input pipe_pkg::addr_t pc);
        @(posedge i_clk);
        i_clear    <= 1'b1;
        i_clear_pc <= pc;
        @(posedge i_clk);
        i_clear <= 1'b0;
        @(negedge i_clk);
        cmp_bit("valid after clear", 1'b0, o_fetch.valid);
        exp_pc = pc;
endtask

task automatic load_and_readback();
        pipe_pkg::word_t rdata;
        logic            err;
        begin_test("load_and_readback");
        @(negedge i_clk);
        cmp_bit("valid after reset", 1'b0, o_fetch.valid);
        cmp_bit("abort after reset", 1'b0, o_fetch.abort);
        cmp_addr("pc_plus_8 after reset", `FETCH_RESET_PC + 32'd8, o_fetch.pc_plus_8);
        cmp_bit("ext pready after reset", 1'b0, o_ext_rsp.pready);
        for (int k = 0; k < `FETCH_MEM_WORDS; k++)
        begin
                model[k] = rand_bits(32);
                ext_xfer(1'b1, 4 * k, model[k], rdata, err);
                cmp_bit($sformatf("write pslverr word %0d", k), 1'b0, err);
        end
        for (int k = 0; k < `FETCH_MEM_WORDS; k++)
        begin
                ext_xfer(1'b0, 4 * k, '0, rdata, err);
                cmp_word($sformatf("read word %0d", k), model[k], rdata);
                cmp_bit($sformatf("read pslverr word %0d", k), 1'b0, err);
        end
        end_test();
endtask

task automatic sequential_fetch();
        begin_test("sequential_fetch");
        @(posedge i_clk);
        i_clear    <= 1'b0;             // Let the sequencer run from 0.
        i_clear_pc <= `FETCH_RESET_PC;
        exp_pc = `FETCH_RESET_PC;
        watch_fetch(N_SEQ, 1'b0);
        end_test();
endtask

task automatic stall_fetch();
        begin_test("stall_fetch");
        watch_fetch(N_STALL, 1'b1);
        end_test();
endtask

task automatic redirect_fetch();
        begin_test("redirect_fetch");
        redirect_to(4 * rand_bits(5));  // Any word in the lower half.
        watch_fetch(N_REDIR, 1'b0);
        end_test();
endtask

task automatic abort_and_wake();
        begin_test("abort_and_wake");
        redirect_to(MEM_BYTES - 8);
        watch_fetch(N_ABORT, 1'b0);     // Third word lies past memory.
        repeat (30)
        begin
                @(negedge i_clk);
                cmp_bit("valid while asleep", 1'b0, o_fetch.valid);
        end
        redirect_to(`FETCH_RESET_PC);   // Wake.
        watch_fetch(N_WAKE, 1'b0);
        end_test();
endtask

task automatic contention_fetch();
        pipe_pkg::word_t rdata;
        logic            err;
        int              idx;
        begin_test("contention_fetch");
        fork
                watch_fetch(N_CONT, 1'b0);
                begin
                        // Top quarter of memory, clear of the fetch window.
                        for (int k = 0; k < 8; k++)
                        begin
                                idx        = `FETCH_MEM_WORDS - 16 + k;
                                model[idx] = rand_bits(32);
                                ext_xfer(1'b1, 4 * idx, model[idx], rdata, err);
                                cmp_bit("ext write pslverr", 1'b0, err);
                                ext_xfer(1'b0, 4 * idx, '0, rdata, err);
                                cmp_word($sformatf("ext read word %0d", idx), model[idx], rdata);
                        end
                end
        join
        end_test();
endtask

`endif

//--- tests/tb_fetch.sv
`timescale 1ns/1ps
`include "fetch_params.svh"

module tb_fetch;

localparam int MEM_BYTES = 4 * `FETCH_MEM_WORDS;
localparam int N_SEQ     = 20;          // Words checked per fetch test.
localparam int N_STALL   = 24;
localparam int N_REDIR   = 12;
localparam int N_ABORT   = 3;           // Two good words, then the abort.
localparam int N_WAKE    = 8;
localparam int N_CONT    = 24;
localparam int N_XFER    = 2 * `FETCH_MEM_WORDS + 16;   // External APB transfers.
localparam int LIMIT     = (N_SEQ + N_STALL + N_REDIR + N_ABORT + N_WAKE + N_CONT
                            + N_XFER) * 8 + 500;

logic                    i_clk;
logic                    i_reset;
logic                    i_clear;
pipe_pkg::addr_t         i_clear_pc;
logic                    i_stall;
bus_pkg::apb_req_t       i_ext_req;
bus_pkg::apb_rsp_t       o_ext_rsp;
pipe_pkg::fetch_bundle_t o_fetch;

pipe_pkg::word_t model [0:`FETCH_MEM_WORDS-1];  // Software copy of code memory.
pipe_pkg::addr_t exp_pc;                        // Next address due on o_fetch.
logic [15:0]     lfsr_q;
string           cur_test;
int              cycles = 0;
int              checks;
int              errors;
int              test_errs;                     // Errors in the running test.
int              tests_run;
int              tests_failed;

initial
begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;      // 8 ns period.
end

fetch_top u_dut (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_clear    (i_clear),
        .i_clear_pc (i_clear_pc),
        .i_stall    (i_stall),
        .i_ext_req  (i_ext_req),
        .o_ext_rsp  (o_ext_rsp),
        .o_fetch    (o_fetch)
);

// Run guard.
always @(posedge i_clk)
begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT)
        begin
                $display("Timeout: the tests did not finish within %0d cycles.", LIMIT);
                $display("Test FAILED");
                $finish;
        end
end

// Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1.
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
endfunction

// Takes n bits, one LFSR step each.
function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++)
        begin
                r      = {r[30:0], lfsr_q[0]};
                lfsr_q = lfsr_next(lfsr_q);
        end
        return r;
endfunction

`include "tb_fetch_tasks.svh"

initial
begin
        i_reset      = 1'b1;
        i_clear      = 1'b1;            // Fetch master idle while memory loads.
        i_clear_pc   = `FETCH_RESET_PC;
        i_stall      = 1'b0;
        i_ext_req    = '0;
        lfsr_q       = 16'd62;
        exp_pc       = `FETCH_RESET_PC;
        checks       = 0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (3) @(posedge i_clk);
        i_reset <= 1'b0;
        load_and_readback();
        sequential_fetch();
        stall_fetch();                  // Picks up right where the last one stopped.
        redirect_fetch();
        abort_and_wake();
        contention_fetch();
        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors.",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0)
                $display("Test OK");
        else
                $display("Test FAILED");
        $finish;
end

endmodule

//--- logic/fetch_top.sv
`timescale 1ns/1ps

module fetch_top
(
        input  logic                    i_clk,
        input  logic                    i_reset,
        input  logic                    i_clear,        // Redirect request.
        input  pipe_pkg::addr_t         i_clear_pc,     // Redirect target.
        input  logic                    i_stall,
        input  bus_pkg::apb_req_t       i_ext_req,      // Maintenance APB master.
        output bus_pkg::apb_rsp_t       o_ext_rsp,
        output pipe_pkg::fetch_bundle_t o_fetch
);

bus_pkg::apb_req_t       fetch_req;     // Sequencer to arbiter.
bus_pkg::apb_rsp_t       fetch_rsp;
bus_pkg::apb_req_t       mem_req;       // Arbiter to memory.
bus_pkg::apb_rsp_t       mem_rsp;
pipe_pkg::fetch_bundle_t seq_bundle;    // Sequencer to buffer.
logic                    take;

pc_sequencer u_seq (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_clear     (i_clear),
        .i_clear_pc  (i_clear_pc),
        .o_fetch_req (fetch_req),
        .i_fetch_rsp (fetch_rsp),
        .o_bundle    (seq_bundle),
        .i_take      (take)
);

apb_arbiter u_arb (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_fetch_req (fetch_req),
        .o_fetch_rsp (fetch_rsp),
        .i_ext_req   (i_ext_req),
        .o_ext_rsp   (o_ext_rsp),
        .o_mem_req   (mem_req),
        .i_mem_rsp   (mem_rsp)
);

code_memory u_mem (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_req   (mem_req),
        .o_rsp   (mem_rsp)
);

fetch_buffer u_buf (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_clear  (i_clear),
        .i_stall  (i_stall),
        .i_bundle (seq_bundle),
        .o_take   (take),
        .o_fetch  (o_fetch)
);

endmodule

//--- logic/fetch_buffer.sv
`timescale 1ns/1ps
`include "fetch_params.svh"

module fetch_buffer
(
        input  logic                    i_clk,
        input  logic                    i_reset,
        input  logic                    i_clear,        // Highest priority after reset.
        input  logic                    i_stall,        // Freeze in place.
        input  pipe_pkg::fetch_bundle_t i_bundle,       // From the sequencer.
        output logic                    o_take,
        output pipe_pkg::fetch_bundle_t o_fetch         // Toward decode.
);

pipe_pkg::fetch_bundle_t fetch_q;
logic                    sleep_q;       // Set by an abort, cleared by a clear.

// Accept only in the normal branch.
assign o_take  = !i_reset && !i_clear && !i_stall && !sleep_q && i_bundle.valid;
assign o_fetch = fetch_q;

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                fetch_q.valid     <= 1'b0;
                fetch_q.abort     <= 1'b0;
                fetch_q.instr     <= '0;
                fetch_q.pc_plus_8 <= `FETCH_RESET_PC + 32'd8;
                sleep_q           <= 1'b0;
        end
        else if (i_clear)
        begin
                fetch_q.valid <= 1'b0;
                fetch_q.abort <= 1'b0;
                fetch_q.instr <= '0;
                sleep_q       <= 1'b0;          // Wake up.
        end
        else if (i_stall)
        begin
                // Hold everything.
        end
        else if (sleep_q)
        begin
                fetch_q.valid <= 1'b0;          // Deliver nothing.
                fetch_q.abort <= 1'b0;
                fetch_q.instr <= '0;
        end
        else
        begin
                fetch_q.valid <= i_bundle.valid;
                fetch_q.abort <= i_bundle.valid && i_bundle.abort;
                if (i_bundle.valid)
                begin
                        fetch_q.instr     <= i_bundle.instr;
                        fetch_q.pc_plus_8 <= i_bundle.pc_plus_8;
                        if (i_bundle.abort)
                                sleep_q <= 1'b1;        // Sleep until cleared.
                end
        end
end

endmodule

//--- logic/code_memory.sv
`timescale 1ns/1ps
`include "fetch_params.svh"

module code_memory
(
        input  logic              i_clk,
        input  logic              i_reset,
        input  bus_pkg::apb_req_t i_req,
        output bus_pkg::apb_rsp_t o_rsp         // Zero wait states.
);

localparam int                IDX_W     = $clog2(`FETCH_MEM_WORDS);
localparam bus_pkg::apb_addr_t MEM_BYTES = 4 * `FETCH_MEM_WORDS;

bus_pkg::apb_data_t mem [0:`FETCH_MEM_WORDS-1];
logic [IDX_W-1:0]   idx;
logic               access;
logic               in_range;

assign idx      = i_req.paddr[IDX_W+1:2];       // Word index, byte lanes dropped.
assign access   = i_req.psel && i_req.penable;
assign in_range = (i_req.paddr < MEM_BYTES);

// Answer every access phase in the same cycle.
always_comb
begin
        o_rsp.pready  = access;
        o_rsp.pslverr = access && !in_range;
        o_rsp.prdata  = in_range ? mem[idx] : '0;       // Zero outside the array.
end

// Writes land at the end of the access phase.
always_ff @(posedge i_clk)
begin
        if (!i_reset && access && i_req.pwrite && in_range)
        begin
                mem[idx] <= i_req.pwdata;
        end
end

endmodule

//--- logic/apb_arbiter.sv
`timescale 1ns/1ps

module apb_arbiter
(
        input  logic              i_clk,
        input  logic              i_reset,
        input  bus_pkg::apb_req_t i_fetch_req,  // Master 0, fetch path.
        output bus_pkg::apb_rsp_t o_fetch_rsp,
        input  bus_pkg::apb_req_t i_ext_req,    // Master 1, maintenance port.
        output bus_pkg::apb_rsp_t o_ext_rsp,
        output bus_pkg::apb_req_t o_mem_req,    // To the code memory.
        input  bus_pkg::apb_rsp_t i_mem_rsp
);

bus_pkg::arb_state_t state_q;
logic                owner_q;           // 1 when the external port owns the bus.
logic                last_q;            // Owner of the last finished transfer.
logic                fetch_wants;
logic                ext_wants;
logic                pick;
logic                fetch_done;
logic                ext_done;
bus_pkg::apb_req_t   own_req;

assign fetch_wants = i_fetch_req.psel;
assign ext_wants   = i_ext_req.psel;

// On a tie the master not served last goes first.
assign pick    = (fetch_wants && ext_wants) ? ~last_q : ext_wants;
assign own_req = owner_q ? i_ext_req : i_fetch_req;

// Owner's address and data, with our own phase strobes.
always_comb
begin
        o_mem_req         = own_req;
        o_mem_req.psel    = (state_q != bus_pkg::ARB_IDLE);
        o_mem_req.penable = (state_q == bus_pkg::ARB_ACCESS);
end

// Only the owner sees pready; the other keeps waiting.
assign fetch_done = (state_q == bus_pkg::ARB_ACCESS) && !owner_q && i_mem_rsp.pready;
assign ext_done   = (state_q == bus_pkg::ARB_ACCESS) && owner_q && i_mem_rsp.pready;

always_comb
begin
        o_fetch_rsp.prdata  = i_mem_rsp.prdata;
        o_fetch_rsp.pready  = fetch_done;
        o_fetch_rsp.pslverr = fetch_done && i_mem_rsp.pslverr;
        o_ext_rsp.prdata    = i_mem_rsp.prdata;
        o_ext_rsp.pready    = ext_done;
        o_ext_rsp.pslverr   = ext_done && i_mem_rsp.pslverr;
end

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                state_q <= bus_pkg::ARB_IDLE;
                owner_q <= 1'b0;
                last_q  <= 1'b1;                // Fetch wins the first tie.
        end
        else
        begin
                case (state_q)
                bus_pkg::ARB_IDLE:
                begin
                        if (fetch_wants || ext_wants)
                        begin
                                owner_q <= pick;
                                state_q <= bus_pkg::ARB_SETUP;
                        end
                end
                bus_pkg::ARB_SETUP: state_q <= bus_pkg::ARB_ACCESS;
                default:
                begin
                        if (i_mem_rsp.pready)
                        begin
                                last_q  <= owner_q;
                                state_q <= bus_pkg::ARB_IDLE;
                        end
                end
                endcase
        end
end

endmodule

//--- logic/pc_sequencer.sv
`timescale 1ns/1ps
`include "fetch_params.svh"

module pc_sequencer
(
        input  logic                    i_clk,
        input  logic                    i_reset,
        input  logic                    i_clear,        // Redirect to i_clear_pc.
        input  pipe_pkg::addr_t         i_clear_pc,
        output bus_pkg::apb_req_t       o_fetch_req,    // Read-only APB master.
        input  bus_pkg::apb_rsp_t       i_fetch_rsp,
        output pipe_pkg::fetch_bundle_t o_bundle,       // Held until i_take.
        input  logic                    i_take
);

pipe_pkg::seq_state_t    state_q;
pipe_pkg::addr_t         pc_q;          // Next address to fetch.
pipe_pkg::addr_t         req_addr_q;    // Address of the read on the bus.
pipe_pkg::fetch_bundle_t bundle_q;
logic                    discard_q;     // Read in flight predates a clear.
logic                    room;

// New read only if the bundle slot is free by the time it returns.
assign room = !bundle_q.valid || i_take;

always_comb
begin
        o_fetch_req         = '0;
        o_fetch_req.paddr   = req_addr_q;
        o_fetch_req.psel    = (state_q == pipe_pkg::SEQ_SETUP) ||
                              (state_q == pipe_pkg::SEQ_ACCESS);
        o_fetch_req.penable = (state_q == pipe_pkg::SEQ_ACCESS);
end

assign o_bundle = bundle_q;

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                state_q        <= pipe_pkg::SEQ_IDLE;
                pc_q           <= `FETCH_RESET_PC;
                discard_q      <= 1'b0;
                bundle_q.valid <= 1'b0;
                bundle_q.abort <= 1'b0;
        end
        else
        begin
                if (i_take)
                        bundle_q.valid <= 1'b0;         // Buffer drained it.
                case (state_q)
                pipe_pkg::SEQ_IDLE:
                begin
                        if (!i_clear && room)
                        begin
                                req_addr_q <= pc_q;     // Frozen for the transfer.
                                state_q    <= pipe_pkg::SEQ_SETUP;
                        end
                end
                pipe_pkg::SEQ_SETUP: state_q <= pipe_pkg::SEQ_ACCESS;
                pipe_pkg::SEQ_ACCESS:
                begin
                        if (i_fetch_rsp.pready)
                        begin
                                discard_q <= 1'b0;
                                state_q   <= pipe_pkg::SEQ_IDLE;
                                if (!discard_q && !i_clear)
                                begin
                                        bundle_q.instr     <= i_fetch_rsp.pslverr ?
                                                              '0 : i_fetch_rsp.prdata;
                                        bundle_q.pc_plus_8 <= req_addr_q + 32'd8;
                                        bundle_q.abort     <= i_fetch_rsp.pslverr;
                                        bundle_q.valid     <= 1'b1;
                                        pc_q               <= pc_q + 32'd4;
                                        if (i_fetch_rsp.pslverr)
                                                state_q <= pipe_pkg::SEQ_HOLD; // Stop fetching.
                                end
                        end
                end
                default: ;                              // HOLD waits for a clear.
                endcase
                if (i_clear)
                begin
                        pc_q           <= i_clear_pc;
                        bundle_q.valid <= 1'b0;         // Drop the held bundle.
                        bundle_q.abort <= 1'b0;
                        // Finish the bus transfer but throw its data away.
                        if (state_q == pipe_pkg::SEQ_SETUP ||
                            (state_q == pipe_pkg::SEQ_ACCESS && !i_fetch_rsp.pready))
                                discard_q <= 1'b1;
                        if (state_q == pipe_pkg::SEQ_HOLD)
                                state_q <= pipe_pkg::SEQ_IDLE;  // Wake.
                end
        end
end

endmodule

//--- logic/pipe_pkg.sv
`include "fetch_params.svh"

package pipe_pkg;

        typedef logic [`FETCH_XLEN-1:0] word_t;         // Instruction or data word.
        typedef logic [`FETCH_XLEN-1:0] addr_t;         // Byte address.

        // One fetched instruction on its way to decode.
        typedef struct packed {
                word_t instr;           // Zero on an abort.
                addr_t pc_plus_8;       // Fetch address plus 8.
                logic  valid;
                logic  abort;           // Fetch hit a slave error.
        } fetch_bundle_t;

        // Sequencer states.
        typedef enum logic [1:0] {
                SEQ_IDLE,       // Free to start a read.
                SEQ_SETUP,      // APB setup phase.
                SEQ_ACCESS,     // APB access phase, waiting for pready.
                SEQ_HOLD        // Stopped after an abort until a clear.
        } seq_state_t;

endpackage

//--- logic/bus_pkg.sv
`include "fetch_params.svh"

package bus_pkg;

        typedef logic [`FETCH_XLEN-1:0] apb_addr_t;     // Byte address on the bus.
        typedef logic [`FETCH_XLEN-1:0] apb_data_t;     // Read or write data word.

        // One master's view of an APB transfer.
        typedef struct packed {
                apb_addr_t paddr;
                apb_data_t pwdata;
                logic      psel;
                logic      penable;
                logic      pwrite;
        } apb_req_t;

        // Slave answer; pslverr counts only with pready.
        typedef struct packed {
                apb_data_t prdata;
                logic      pready;
                logic      pslverr;
        } apb_rsp_t;

        typedef enum logic [1:0] {ARB_IDLE, ARB_SETUP, ARB_ACCESS} arb_state_t;

endpackage

//--- logic/fetch_params.svh
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// Data and address width in bits.
`define FETCH_XLEN 32

// Code memory depth in words.
`define FETCH_MEM_WORDS 64

// First fetch address after reset.
`define FETCH_RESET_PC 32'h0000_0000

`endif
